/* opl_fm_macros.svh */
/*
 * FM operator engine sizes
 * Operator count, datapath widths, sample period and APB register map
 */
`ifndef OPL_FM_MACROS_SVH
`define OPL_FM_MACROS_SVH

`define OPL_NUM_OPS        8
`define OPL_OP_W           3
`define OPL_PHASE_ACC_W    20
`define OPL_PHASE_FINAL_W  10   // Top bits of the accumulator used as table phase
`define OPL_ENV_W          9
`define OPL_OUT_W          13
`define OPL_SAMPLE_PERIOD  16   // Clocks between bursts, at least OPL_NUM_OPS

// APB byte addresses, per-operator registers at a stride of 4
`define OPL_ADDR_CTRL       8'h00
`define OPL_ADDR_FREQ_BASE  8'h10
`define OPL_ADDR_OP_BASE    8'h30

`endif

/* source/opl_fm_pkg.sv */
/*
 * FM operator engine types
 * Register layouts, the APB write word, the operator slot, and the
 * formulas behind the log-sine and exponent tables
 */
`default_nettype none
`include "opl_fm_macros.svh"

package opl_fm_pkg;

    typedef struct packed {
        logic [31-`OPL_PHASE_ACC_W:0] rsvd;
        logic [`OPL_PHASE_ACC_W-1:0]  phase_inc;
    } freq_reg_t;

    typedef struct packed {
        logic [18:0]           rsvd;
        logic                  key_on;  // Bit 12
        logic [2:0]            ws;      // Bits 11:9
        logic [`OPL_ENV_W-1:0] env;     // Bits 8:0
    } op_reg_t;

    // One APB write word, read as either layout depending on the address
    typedef union packed {
        freq_reg_t freq;
        op_reg_t   op;
    } reg_word_u;

    typedef struct packed {
        logic [`OPL_OP_W-1:0]        op_num;
        logic [`OPL_PHASE_ACC_W-1:0] phase_inc;
        logic [2:0]                  ws;      // Already masked for mode
        logic [`OPL_ENV_W-1:0]       env;
        logic                        key_on;
    } op_slot_t;

    // round(-log2(sin((i + 0.5) * pi / 512)) * 256)
    function automatic logic [11:0] log_sin_entry(input int i);
        real x;
        x = -$ln($sin((i + 0.5) * 3.14159265358979 / 512.0)) / $ln(2.0) * 256.0;
        return 12'($rtoi(x + 0.5));
    endfunction

    // round((2^(i/256) - 1) * 1024)
    function automatic logic [9:0] exp_entry(input int i);
        real x;
        x = ($pow(2.0, i / 256.0) - 1.0) * 1024.0;
        return 10'($rtoi(x + 0.5));
    endfunction

endpackage

`default_nettype wire

/* source/op_reg_file.sv */
/*
 * Operator register file
 * APB3 slave holding the control word and the frequency and operator
 * registers of every operator. Key-on writes are kept as pending bits
 * until the sequencer issues that operator's slot.
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl_fm_macros.svh"

module op_reg_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire  [7:0]                paddr,
    input  wire  [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  wire  [`OPL_OP_W-1:0]      op_sel,
    input  wire                       key_ack,
    output logic                      run,
    output logic                      is_new,
    output opl_fm_pkg::freq_reg_t     sel_freq,
    output opl_fm_pkg::op_reg_t       sel_op,
    output logic [`OPL_NUM_OPS-1:0]   key_pending
);
    import opl_fm_pkg::*;

    freq_reg_t            freq_q [`OPL_NUM_OPS];
    op_reg_t              op_q [`OPL_NUM_OPS];
    reg_word_u            wr_word;
    freq_reg_t            freq_wr;
    op_reg_t              op_wr;
    logic [7:0]           freq_off;
    logic [7:0]           op_off;
    logic [`OPL_OP_W-1:0] freq_idx;
    logic [`OPL_OP_W-1:0] op_idx;
    logic                 hit_ctrl;
    logic                 hit_freq;
    logic                 hit_op;
    logic                 setup;
    logic                 access;
    logic [31:0]          rd_word;

    // ******************************************************************
    // Address decode
    // ******************************************************************
    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign freq_off = paddr - `OPL_ADDR_FREQ_BASE;  // Wraps high below the base
    assign op_off   = paddr - `OPL_ADDR_OP_BASE;
    assign freq_idx = freq_off[`OPL_OP_W+1:2];
    assign op_idx   = op_off[`OPL_OP_W+1:2];

    assign hit_ctrl = (paddr == `OPL_ADDR_CTRL);
    assign hit_freq = (freq_off < 8'(4 * `OPL_NUM_OPS)) && (freq_off[1:0] == 2'b00);
    assign hit_op   = (op_off < 8'(4 * `OPL_NUM_OPS)) && (op_off[1:0] == 2'b00);

    assign wr_word = pwdata;
    assign pready  = 1'b1;  // No wait states

    // Only defined fields are stored and key-on is only a trigger
    always_comb begin
        freq_wr      = wr_word.freq;
        freq_wr.rsvd = '0;
        op_wr        = wr_word.op;
        op_wr.rsvd   = '0;
        op_wr.key_on = 1'b0;
    end

    // ******************************************************************
    // Register writes and key-on tracking
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            run         <= 1'b0;
            is_new      <= 1'b0;
            key_pending <= '0;
            for (int i = 0; i < `OPL_NUM_OPS; i++) begin
                freq_q[i] <= '0;
                op_q[i]   <= '0;
            end
        end else begin
            if (key_ack)
                key_pending[op_sel] <= 1'b0;
            if (access && pwrite) begin
                if (hit_ctrl) begin
                    run    <= pwdata[0];
                    is_new <= pwdata[1];
                end
                if (hit_freq)
                    freq_q[freq_idx] <= freq_wr;
                if (hit_op) begin
                    op_q[op_idx] <= op_wr;
                    if (wr_word.op.key_on)
                        key_pending[op_idx] <= 1'b1;  // A new write wins over the ack
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (hit_ctrl)
            rd_word = {30'b0, is_new, run};
        else if (hit_freq)
            rd_word = freq_q[freq_idx];
        else if (hit_op)
            rd_word = op_q[op_idx];
    end

    // Read data and error are captured in setup so they are valid in access
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && !(hit_ctrl || hit_freq || hit_op);
            if (setup && !pwrite)
                prdata <= rd_word;
        end
    end

    assign sel_freq = freq_q[op_sel];
    assign sel_op   = op_q[op_sel];

endmodule

`default_nettype wire

/* source/op_sequencer.sv */
/*
 * Operator sequencer
 * Counts the sample period and issues one slot per clock for all
 * operators at the start of each period while running
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl_fm_macros.svh"

module op_sequencer (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       run,
    input  wire                       is_new,
    input  var opl_fm_pkg::freq_reg_t sel_freq,
    input  var opl_fm_pkg::op_reg_t   sel_op,
    input  wire  [`OPL_NUM_OPS-1:0]   key_pending,
    output logic [`OPL_OP_W-1:0]      op_sel,
    output logic                      key_ack,
    output logic                      slot_valid,
    output opl_fm_pkg::op_slot_t      slot
);
    localparam int CNT_W = $clog2(`OPL_SAMPLE_PERIOD);

    logic [CNT_W-1:0] cnt;
    logic             active;
    logic             issue;
    logic [2:0]       ws_mask;

    // A burst once started always runs to the end of its period
    assign active  = run || (cnt != '0);
    assign issue   = active && (int'(cnt) < `OPL_NUM_OPS);
    assign op_sel  = cnt[`OPL_OP_W-1:0];
    assign key_ack = issue && key_pending[op_sel];
    assign ws_mask = is_new ? 3'd7 : 3'd3;  // Old mode has four waveforms

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (active)
            cnt <= (cnt == CNT_W'(`OPL_SAMPLE_PERIOD - 1)) ? '0 : cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            slot_valid <= 1'b0;
        else
            slot_valid <= issue;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            slot.op_num    <= op_sel;
            slot.phase_inc <= sel_freq.phase_inc;
            slot.ws        <= sel_op.ws & ws_mask;
            slot.env       <= sel_op.env;
            slot.key_on    <= key_pending[op_sel];
        end
    end

endmodule

`default_nettype wire

/* source/log_sine_rom.sv */
/*
 * Log-sine table
 * Quarter-wave -log2(sin) lookup, one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module log_sine_rom (
    input  wire         clk,
    input  wire  [7:0]  theta,
    output logic [11:0] out
);
    import opl_fm_pkg::*;

    logic [11:0] rom [256];

    initial begin
        for (int i = 0; i < 256; i++)
            rom[i] = log_sin_entry(i);
    end

    always_ff @(posedge clk)
        out <= rom[theta];

endmodule

`default_nettype wire

/* source/exp_rom.sv */
/*
 * Exponent table
 * Fractional 2^x lookup, one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

module exp_rom (
    input  wire        clk,
    input  wire  [7:0] in,
    output logic [9:0] out
);
    import opl_fm_pkg::*;

    logic [9:0] rom [256];

    initial begin
        for (int i = 0; i < 256; i++)
            rom[i] = exp_entry(i);
    end

    always_ff @(posedge clk)
        out <= rom[in];

endmodule

`default_nettype wire

/* source/phase_generator.sv */
/*
 * Phase generator
 * Six-stage pipeline per operator slot: phase accumulation, odd-period
 * tracking, log-sine and exponent lookups, and waveform shaping into a
 * signed sample
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl_fm_macros.svh"

module phase_generator (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          slot_valid,
    input  var opl_fm_pkg::op_slot_t     slot,
    output logic                         sample_valid,
    output logic [`OPL_OP_W-1:0]         sample_op,
    output logic signed [`OPL_OUT_W-1:0] sample_out
);
    import opl_fm_pkg::*;

    localparam int DEPTH  = 6;
    localparam int GAIN_W = 13;

    op_slot_t                     slot_p [1:DEPTH];  // Slot carried down the pipe
    logic [DEPTH:1]               valid_p;

    // Per-operator state
    logic [`OPL_PHASE_ACC_W-1:0]  acc_mem [`OPL_NUM_OPS];
    logic [`OPL_NUM_OPS-1:0]      msb_mem;
    logic [`OPL_NUM_OPS-1:0]      odd_mem;

    logic [`OPL_PHASE_ACC_W-1:0]  acc_p1;
    logic [`OPL_PHASE_ACC_W-1:0]  acc_p2;
    logic [`OPL_PHASE_ACC_W-1:0]  phase_acc_p3;
    logic [4:1]                   msb_p;
    logic [DEPTH:1]               odd_p;
    logic [`OPL_PHASE_FINAL_W-1:0] final_phase_p4;
    logic [`OPL_PHASE_FINAL_W-1:0] final_phase_p5;
    logic [`OPL_PHASE_FINAL_W-1:0] final_phase_p6;
    logic [7:0]                   theta_p4;
    logic [11:0]                  log_sin_p5;
    logic [11:0]                  ws7_p5;
    logic [11:0]                  env_term_p5;
    logic [GAIN_W-1:0]            gain_p5;
    logic [GAIN_W-1:0]            gain_p6;
    logic [9:0]                   exp_p6;
    logic [`OPL_OUT_W-1:0]        mag_p6;
    logic signed [`OPL_OUT_W-1:0] wave_p6;
    logic signed [`OPL_OUT_W-1:0] abs_p6;
    logic signed [`OPL_OUT_W-1:0] odd_wave_p6;

    always_ff @(posedge clk) begin
        slot_p[1] <= slot;
        for (int k = 2; k <= DEPTH; k++)
            slot_p[k] <= slot_p[k-1];
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_p <= '0;
        else
            valid_p <= {valid_p[DEPTH-1:1], slot_valid};
    end

    // ******************************************************************
    // Operator state, read at p0 with two cycles latency
    // ******************************************************************
    always_ff @(posedge clk) begin
        acc_p1     <= acc_mem[slot.op_num];
        acc_p2     <= acc_p1;
        msb_p      <= {msb_p[3:1], msb_mem[slot.op_num]};
        odd_p[4:1] <= {odd_p[3:1], odd_mem[slot.op_num]};
        // Odd period flips when the phase MSB falls
        odd_p[5]   <= (msb_p[4] && !final_phase_p4[9]) ? !odd_p[4] : odd_p[4];
        odd_p[6]   <= odd_p[5];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            msb_mem <= '0;
            odd_mem <= '0;
            for (int i = 0; i < `OPL_NUM_OPS; i++)
                acc_mem[i] <= '0;
        end else begin
            if (valid_p[3])
                acc_mem[slot_p[3].op_num] <= phase_acc_p3;
            if (valid_p[4])
                msb_mem[slot_p[4].op_num] <= final_phase_p4[9];
            if (valid_p[5])
                odd_mem[slot_p[5].op_num] <= odd_p[5];
        end
    end

    always_ff @(posedge clk) begin
        if (slot_p[2].key_on)
            phase_acc_p3 <= '0;
        else if (slot_p[2].ws == 3'd4 || slot_p[2].ws == 3'd5)
            phase_acc_p3 <= acc_p2 + (slot_p[2].phase_inc << 1);  // Double rate
        else
            phase_acc_p3 <= acc_p2 + slot_p[2].phase_inc;
    end

    // ******************************************************************
    // Table lookups and attenuation
    // ******************************************************************
    always_ff @(posedge clk) begin
        final_phase_p4 <= phase_acc_p3[`OPL_PHASE_ACC_W-1 -: `OPL_PHASE_FINAL_W];
        final_phase_p5 <= final_phase_p4;
        final_phase_p6 <= final_phase_p5;
        // Ramp for ws 7, MSB set mutes the middle two quadrants
        ws7_p5 <= {final_phase_p4[9] ^ final_phase_p4[8],
                   final_phase_p4[9] ? ~final_phase_p4[7:0] : final_phase_p4[7:0],
                   3'b000};
        gain_p6 <= gain_p5;
    end

    assign theta_p4 = final_phase_p4[8] ? ~final_phase_p4[7:0] : final_phase_p4[7:0];

    log_sine_rom u_log_sine (
        .clk,
        .theta (theta_p4),
        .out   (log_sin_p5)
    );

    assign env_term_p5 = {slot_p[5].env, 3'b000};

    always_comb begin
        case (slot_p[5].ws)
            3'd6:    gain_p5 = env_term_p5;           // Square, no sine term
            3'd7:    gain_p5 = ws7_p5 + env_term_p5;
            default: gain_p5 = log_sin_p5 + env_term_p5;
        endcase
    end

    exp_rom u_exp (
        .clk,
        .in  (~gain_p5[7:0]),
        .out (exp_p6)
    );

    // ******************************************************************
    // Waveform shaping
    // ******************************************************************
    assign mag_p6      = {1'b0, 1'b1, exp_p6, 1'b0} >> gain_p6[GAIN_W-1:8];
    assign wave_p6     = final_phase_p6[9] ? ~mag_p6 : mag_p6;  // Negative half
    assign abs_p6      = (wave_p6 < 0) ? ~wave_p6 : wave_p6;
    assign odd_wave_p6 = odd_p[6] ? wave_p6 : '0;

    always_comb begin
        case (slot_p[6].ws)
            3'd1:    sample_out = (wave_p6 < 0) ? '0 : wave_p6;
            3'd2:    sample_out = abs_p6;
            3'd3:    sample_out = final_phase_p6[8] ? '0 : abs_p6;  // Pulsed
            3'd4:    sample_out = odd_wave_p6;
            3'd5:    sample_out = (odd_wave_p6 < 0) ? ~odd_wave_p6 : odd_wave_p6;
            default: sample_out = wave_p6;  // Full wave for 0, 6 and 7
        endcase
    end

    assign sample_valid = valid_p[DEPTH];
    assign sample_op    = slot_p[DEPTH].op_num;

endmodule

`default_nettype wire

/* source/opl_fm_top.sv */
/*
 * FM operator engine top
 * APB register file, operator sequencer and phase generator
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl_fm_macros.svh"

module opl_fm_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [7:0]                   paddr,
    input  wire  [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         sample_valid,
    output logic [`OPL_OP_W-1:0]         sample_op,
    output logic signed [`OPL_OUT_W-1:0] sample_out
);
    import opl_fm_pkg::*;

    logic [`OPL_OP_W-1:0]    op_sel;
    logic                    key_ack;
    logic                    run;
    logic                    is_new;
    freq_reg_t               sel_freq;
    op_reg_t                 sel_op;
    logic [`OPL_NUM_OPS-1:0] key_pending;
    logic                    slot_valid;
    op_slot_t                slot;

    op_reg_file u_reg_file (
        .clk,
        .rst,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .pready,
        .pslverr,
        .op_sel,
        .key_ack,
        .run,
        .is_new,
        .sel_freq,
        .sel_op,
        .key_pending
    );

    op_sequencer u_sequencer (
        .clk,
        .rst,
        .run,
        .is_new,
        .sel_freq,
        .sel_op,
        .key_pending,
        .op_sel,
        .key_ack,
        .slot_valid,
        .slot
    );

    phase_generator u_phase_gen (
        .clk,
        .rst,
        .slot_valid,
        .slot,
        .sample_valid,
        .sample_op,
        .sample_out
    );

endmodule

`default_nettype wire

/* verif/opl_fm_model.svh */
/*
 * Reference model of the FM operator engine
 * Register image built from APB writes, per-operator phase state,
 * and the table and waveform arithmetic behind each expected sample
 */
`ifndef OPL_FM_MODEL_SVH
`define OPL_FM_MODEL_SVH

int ref_inc [`OPL_NUM_OPS];
int ref_ws [`OPL_NUM_OPS];
int ref_env [`OPL_NUM_OPS];
bit ref_key [`OPL_NUM_OPS];     // Key-on written, not yet taken by a slot
int ref_acc [`OPL_NUM_OPS];
bit ref_msb [`OPL_NUM_OPS];     // Final-phase MSB of the previous slot
bit ref_odd [`OPL_NUM_OPS];
bit ref_run;
bit ref_is_new;
int ref_log_sin [256];
int ref_exp [256];

function automatic void clear_state();
    ref_run = 1'b0;
    ref_is_new = 1'b0;
    for (int i = 0; i < `OPL_NUM_OPS; i++) begin
        ref_inc[i] = 0;
        ref_ws[i] = 0;
        ref_env[i] = 0;
        ref_key[i] = 1'b0;
        ref_acc[i] = 0;
        ref_msb[i] = 1'b0;
        ref_odd[i] = 1'b0;
    end
    for (int i = 0; i < 256; i++) begin
        ref_log_sin[i] = int'(log_sin_entry(i));
        ref_exp[i] = int'(exp_entry(i));
    end
endfunction

function automatic bit is_mapped(input logic [7:0] addr);
    int a;
    a = int'(addr);
    if (a == int'(`OPL_ADDR_CTRL))
        return 1'b1;
    if (a % 4 != 0)
        return 1'b0;
    return (a >= int'(`OPL_ADDR_FREQ_BASE) && a < int'(`OPL_ADDR_FREQ_BASE) + 4 * `OPL_NUM_OPS)
        || (a >= int'(`OPL_ADDR_OP_BASE) && a < int'(`OPL_ADDR_OP_BASE) + 4 * `OPL_NUM_OPS);
endfunction

function automatic void record_write(input logic [7:0] addr, input logic [31:0] data);
    int a;
    int idx;
    a = int'(addr);
    if (!is_mapped(addr))
        return;                  // Ignored by the register file
    if (a == int'(`OPL_ADDR_CTRL)) begin
        ref_run = data[0];
        ref_is_new = data[1];
    end else if (a < int'(`OPL_ADDR_OP_BASE)) begin
        idx = (a - int'(`OPL_ADDR_FREQ_BASE)) / 4;
        ref_inc[idx] = int'(data[`OPL_PHASE_ACC_W-1:0]);
    end else begin
        idx = (a - int'(`OPL_ADDR_OP_BASE)) / 4;
        ref_ws[idx] = int'(data[11:9]);
        ref_env[idx] = int'(data[8:0]);
        if (data[12])
            ref_key[idx] = 1'b1;
    end
endfunction

function automatic logic [31:0] expected_read(input logic [7:0] addr);
    int a;
    a = int'(addr);
    if (!is_mapped(addr))
        return 32'h0;
    if (a == int'(`OPL_ADDR_CTRL))
        return {30'b0, ref_is_new, ref_run};
    if (a < int'(`OPL_ADDR_OP_BASE))
        return 32'(ref_inc[(a - int'(`OPL_ADDR_FREQ_BASE)) / 4]);
    a = (a - int'(`OPL_ADDR_OP_BASE)) / 4;
    return 32'(ref_ws[a] * 512 + ref_env[a]);   // Key-on always reads 0
endfunction

// Sample for a 10-bit final phase, waveform, attenuation and odd-period bit
function automatic int shape_sample(input int fph, input int ws, input int env, input bit odd);
    int q8;
    int q9;
    int low;
    int theta;
    int gain;
    int mag;
    int wave;
    int absw;
    q8 = (fph / 256) % 2;
    q9 = fph / 512;
    low = fph % 256;
    theta = (q8 == 1) ? 255 - low : low;     // Quarter-wave mirror
    case (ws)
        6:       gain = env * 8;
        7:       gain = ((q9 != q8) ? 2048 : 0) + 8 * ((q9 == 1) ? 255 - low : low) + env * 8;
        default: gain = ref_log_sin[theta] + env * 8;
    endcase
    mag = (2048 + 2 * ref_exp[255 - gain % 256]) >> (gain / 256);
    wave = (q9 == 1) ? -mag - 1 : mag;
    absw = (wave < 0) ? -wave - 1 : wave;
    case (ws)
        1:       return (wave < 0) ? 0 : wave;
        2:       return absw;
        3:       return (q8 == 1) ? 0 : absw;
        4:       return odd ? wave : 0;
        5:       return odd ? absw : 0;
        default: return wave;
    endcase
endfunction

// Advance one operator by a slot and give its expected sample
function automatic int next_sample(input int op);
    int ws;
    int fph;
    bit key;
    ws = ref_is_new ? ref_ws[op] : ref_ws[op] % 4;
    key = ref_key[op];
    ref_key[op] = 1'b0;
    if (key)
        ref_acc[op] = 0;
    else if (ws == 4 || ws == 5)
        ref_acc[op] = (ref_acc[op] + 2 * ref_inc[op]) % (1 << `OPL_PHASE_ACC_W);
    else
        ref_acc[op] = (ref_acc[op] + ref_inc[op]) % (1 << `OPL_PHASE_ACC_W);
    fph = ref_acc[op] >> (`OPL_PHASE_ACC_W - `OPL_PHASE_FINAL_W);
    if (ref_msb[op] && fph < 512)
        ref_odd[op] = !ref_odd[op];
    ref_msb[op] = (fph >= 512);
    return shape_sample(fph, ws, ref_env[op], ref_odd[op]);
endfunction

`endif

/* verif/opl_fm_tb.sv */
/*
 * Testbench for the FM operator engine
 * Drives APB register traffic with random settings, runs bursts and
 * compares every sample with the reference model
 */
`timescale 1ns/1ps
`default_nettype none
`include "opl_fm_macros.svh"

module opl_fm_tb;
    import opl_fm_pkg::*;

    localparam int TIMEOUT = 5000;   // Cycles allowed for any single wait

    logic                         clk;
    logic                         rst;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [7:0]                   paddr;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic                         sample_valid;
    logic [`OPL_OP_W-1:0]         sample_op;
    logic signed [`OPL_OUT_W-1:0] sample_out;

    integer seed;
    int     cycle = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     seen_op [$];
    int     seen_cyc [$];
    int     seen_val [$];

    `include "opl_fm_model.svh"

    opl_fm_top u_dut (
        .clk,
        .rst,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .pready,
        .pslverr,
        .sample_valid,
        .sample_op,
        .sample_out
    );

    always #50 clk = ~clk;

    always @(posedge clk)
        cycle++;

    // ******************************************************************
    // Sample monitor checking every output against the model
    // ******************************************************************
    always @(negedge clk) begin
        int expected;
        if (!rst && sample_valid) begin
            expected = next_sample(int'(sample_op));
            seen_op.push_back(int'(sample_op));
            seen_cyc.push_back(cycle);
            seen_val.push_back(int'(sample_out));
            checks++;
            if ($isunknown(sample_out) || int'(sample_out) != expected) begin
                $display("Fail at %0t ns: sample_out (op %0d) got %0d, expected %0d",
                         $time, sample_op, sample_out, expected);
                errors++;
            end
        end
    end

    task automatic timeout_abort(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic apb_access(input logic [7:0] addr, input bit wr, input logic [31:0] data,
                              output logic [31:0] rdata, output bit err);
        int n;
        @(posedge clk);
        #1;
        psel = 1'b1;     // Setup phase
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(negedge clk);
        if (pready !== 1'b1) begin
            $display("Fail at %0t ns: pready got %b, expected 1", $time, pready);
            errors++;
        end
        while (!pready) begin
            n++;
            if (n == TIMEOUT)
                timeout_abort("pready");
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic check_err(input logic [7:0] addr, input bit got);
        if (got != !is_mapped(addr)) begin
            $display("Fail at %0t ns: pslverr at 0x%02h got %0d, expected %0d",
                     $time, addr, got, !is_mapped(addr));
            errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        bit          err;
        apb_access(addr, 1'b1, data, rdata, err);
        record_write(addr, data);
        check_err(addr, err);
    endtask

    task automatic check_read(input logic [7:0] addr);
        logic [31:0] rdata;
        logic [31:0] expected;
        bit          err;
        expected = expected_read(addr);
        apb_access(addr, 1'b0, 32'h0, rdata, err);
        check_err(addr, err);
        if (is_mapped(addr) && rdata !== expected) begin
            $display("Fail at %0t ns: prdata at 0x%02h got 0x%08h, expected 0x%08h",
                     $time, addr, rdata, expected);
            errors++;
        end
    endtask

    task automatic wait_samples(input int count);
        int n;
        n = 0;
        while (seen_op.size() < count) begin
            @(negedge clk);
            n++;
            if (n == TIMEOUT)
                timeout_abort("samples from the engine");
        end
    endtask

    // Idle once no sample shows up for more than a whole period
    task automatic wait_idle();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < `OPL_SAMPLE_PERIOD + 8) begin
            @(negedge clk);
            quiet = sample_valid ? 0 : quiet + 1;
            n++;
            if (n == TIMEOUT)
                timeout_abort("the engine to go idle");
        end
    endtask

    task automatic run_bursts(input bit new_mode, input int bursts);
        seen_op.delete();
        seen_cyc.delete();
        seen_val.delete();
        apb_write(`OPL_ADDR_CTRL, {30'b0, new_mode, 1'b1});
        wait_samples(bursts * `OPL_NUM_OPS);
        apb_write(`OPL_ADDR_CTRL, {30'b0, new_mode, 1'b0});
        wait_idle();
    endtask

    // ws_mode 0 gives sine only, 1 random waveforms, 2 waveforms 4 to 7
    task automatic load_operators(input int ws_mode);
        logic [31:0] w;
        for (int op = 0; op < `OPL_NUM_OPS; op++) begin
            w = $random(seed);
            apb_write(8'(`OPL_ADDR_FREQ_BASE + 4 * op), w & 32'h000F_FFFF);
            w = $random(seed);
            w[31:12] = '0;
            w[8:6] = 3'b000;     // Low attenuation keeps the output away from zero
            if (ws_mode == 0)
                w[11:9] = 3'd0;
            else if (ws_mode == 2)
                w[11:9] = 3'(4 + op % 4);
            apb_write(8'(`OPL_ADDR_OP_BASE + 4 * op), w);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
    endtask

    // ******************************************************************
    // Test sequence
    // ******************************************************************
    initial begin
        int          mark;
        int          key_op;
        int          env;
        int          first;
        int          expected;
        logic [7:0]  bad_addr [4];
        logic [31:0] w;
        clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed = 4;
        bad_addr = '{8'h04, 8'h12, 8'h50, 8'hfc};
        clear_state();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        mark = errors;
        for (int op = 0; op < `OPL_NUM_OPS; op++) begin
            apb_write(8'(`OPL_ADDR_FREQ_BASE + 4 * op), $random(seed));
            check_read(8'(`OPL_ADDR_FREQ_BASE + 4 * op));
            apb_write(8'(`OPL_ADDR_OP_BASE + 4 * op), $random(seed));
            check_read(8'(`OPL_ADDR_OP_BASE + 4 * op));
        end
        w = $random(seed);
        apb_write(`OPL_ADDR_CTRL, {30'b0, w[1], 1'b0});   // Stay stopped
        check_read(`OPL_ADDR_CTRL);
        foreach (bad_addr[i]) begin
            apb_write(bad_addr[i], $random(seed));
            check_read(bad_addr[i]);
        end
        finish_test("register access", mark);

        mark = errors;
        load_operators(0);
        run_bursts(1'b1, 4);
        foreach (seen_op[i]) begin
            expected = seen_cyc[0] + (i / 8) * `OPL_SAMPLE_PERIOD + i % 8;
            if (seen_op[i] != i % 8) begin
                $display("Fail at %0t ns: sample_op at sample %0d got %0d, expected %0d",
                         $time, i, seen_op[i], i % 8);
                errors++;
            end
            if (seen_cyc[i] != expected) begin
                $display("Fail at %0t ns: sample_valid for sample %0d at cycle %0d, expected %0d",
                         $time, i, seen_cyc[i], expected);
                errors++;
            end
        end
        seen_op.delete();
        repeat (3 * `OPL_SAMPLE_PERIOD) @(negedge clk);
        if (seen_op.size() != 0) begin
            $display("Samples appeared while run was 0");
            errors++;
        end
        finish_test("slot order", mark);

        mark = errors;
        load_operators(0);
        run_bursts(1'b1, 20);
        finish_test("sine accuracy", mark);

        mark = errors;
        load_operators(1);
        run_bursts(1'b1, 40);
        finish_test("all waveforms", mark);

        mark = errors;
        load_operators(2);
        run_bursts(1'b0, 30);
        finish_test("old mode", mark);

        // Key-on restarts one operator from phase 0 with ws 0
        mark = errors;
        key_op = $random(seed) & 7;
        env = $random(seed) & 63;
        apb_write(8'(`OPL_ADDR_OP_BASE + 4 * key_op), 32'h0000_1000 | 32'(env));
        run_bursts(1'b1, 3);
        first = -1;
        foreach (seen_op[i]) begin
            if (first < 0 && seen_op[i] == key_op)
                first = i;
        end
        expected = shape_sample(0, 0, env, 1'b0);
        if (first < 0) begin
            $display("No sample came out for the keyed operator %0d", key_op);
            errors++;
        end else if (seen_val[first] != expected) begin
            $display("Fail at %0t ns: sample_out after key-on (op %0d) got %0d, expected %0d",
                     $time, key_op, seen_val[first], expected);
            errors++;
        end
        finish_test("key-on", mark);

        $display("Tests run %0d, failed %0d, sample checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* opl_fm_top.f */
+incdir+.
+incdir+verif
source/opl_fm_pkg.sv
source/op_reg_file.sv
source/op_sequencer.sv
source/log_sine_rom.sv
source/exp_rom.sv
source/phase_generator.sv
source/opl_fm_top.sv
verif/opl_fm_tb.sv

/* Makefile */
TOP = opl_fm_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f opl_fm_top.f --top-module opl_fm_top

sim:
	verilator --binary --timing -Wno-fatal -f opl_fm_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
